//--- src/screen_pkg.sv
`default_nettype none

package screen_pkg;

	//////////////////////////////////////////////////////////////////////
	// game state codes
	//////////////////////////////////////////////////////////////////////
	typedef logic [3:0] fsm_state_t; // game FSM state

	localparam fsm_state_t ST_IDLE       = 4'd0; // waiting room
	localparam fsm_state_t ST_COUNT_DOWN = 4'd1; // this screen
	localparam fsm_state_t ST_CHAT       = 4'd2; // after the count

	//////////////////////////////////////////////////////////////////////
	// keypad codes
	//////////////////////////////////////////////////////////////////////
	typedef logic [3:0] key_t; // keypad scanner code

	localparam key_t KEY_0    = 4'h0;
	localparam key_t KEY_1    = 4'h1;
	localparam key_t KEY_2    = 4'h2;
	localparam key_t KEY_4    = 4'h4;
	localparam key_t KEY_5    = 4'h5;
	localparam key_t KEY_7    = 4'h7;
	localparam key_t KEY_8    = 4'h8;
	localparam key_t KEY_A    = 4'hA;
	localparam key_t KEY_NONE = 4'hF; // nothing pressed

	//////////////////////////////////////////////////////////////////////
	// emotion codes, sent between the boards
	//////////////////////////////////////////////////////////////////////
	typedef logic [3:0] emotion_t;

	localparam emotion_t EMO_SMILE  = 4'd0;
	localparam emotion_t EMO_ANGRY  = 4'd1;
	localparam emotion_t EMO_SLEEPY = 4'd2;
	localparam emotion_t EMO_SHINE  = 4'd3;
	localparam emotion_t EMO_LOVE   = 4'd4;
	localparam emotion_t EMO_SAD    = 4'd5;
	localparam emotion_t EMO_LIKE   = 4'd6;
	localparam emotion_t EMO_SCORN  = 4'd7;
	localparam emotion_t EMO_NONE   = 4'd8; // no emotion picked

	//////////////////////////////////////////////////////////////////////
	// LCD glyph bytes
	//////////////////////////////////////////////////////////////////////
	typedef logic [7:0] glyph_t; // one character cell

	// emotion faces live in the eight CGRAM slots, same order as codes
	localparam glyph_t GLYPH_SMILE   = 8'h00;
	localparam glyph_t GLYPH_ANGRY   = 8'h01;
	localparam glyph_t GLYPH_SLEEPY  = 8'h02;
	localparam glyph_t GLYPH_SHINE   = 8'h03;
	localparam glyph_t GLYPH_LOVE    = 8'h04;
	localparam glyph_t GLYPH_SAD     = 8'h05;
	localparam glyph_t GLYPH_LIKE    = 8'h06;
	localparam glyph_t GLYPH_SCORN   = 8'h07;
	localparam glyph_t GLYPH_BLANK   = 8'h20; // ascii space
	localparam glyph_t GLYPH_GO      = 8'h47; // 'G', shown at zero
	localparam glyph_t GLYPH_DIGIT_0 = 8'h30; // ascii '0', add the digit
	localparam glyph_t GLYPH_COLON   = 8'h3A; // ascii ':'

	localparam int ROW_BYTES = 16; // cells per LCD row

	typedef glyph_t [ROW_BYTES-1:0] screen_row_t; // index 15 is leftmost

endpackage

`default_nettype wire

//--- src/emotion_if.sv
`timescale 1ns/1ps
`default_nettype none

interface emotion_if (
	input logic clk // sampling clock for checks
);
	screen_pkg::key_t     key;          // raw keypad code
	logic                 key_valid;    // debounced press level
	screen_pkg::emotion_t code_out;     // to the other board
	screen_pkg::glyph_t   glyph_local;  // own face
	screen_pkg::emotion_t code_in;      // from the other board
	screen_pkg::glyph_t   glyph_remote; // partner face

	// key side in, codes and glyphs out
	modport codec (input clk, key, key_valid, code_in,
		output code_out, glyph_local, glyph_remote);

	// screen feeds the key side and reads the results
	modport screen (output key, key_valid, code_in,
		input code_out, glyph_local, glyph_remote);
endinterface

`default_nettype wire

//--- src/debounce.sv
`timescale 1ns/1ps
`default_nettype none

module debounce #(
	parameter int SAMPLE_CYCLES = 4 // clocks between samples
) (
	input  logic clk,
	input  logic rst_n,
	input  logic pb_in,         // raw press level
	output logic pb_debounced   // filtered level
);
	localparam int CNT_W = (SAMPLE_CYCLES > 1) ? $clog2(SAMPLE_CYCLES) : 1;

	logic [CNT_W-1:0] smp_cnt; // sample prescaler
	logic             smp_en;  // one clock per sample
	logic [3:0]       history; // last four samples, newest in bit 0

	assign smp_en = (smp_cnt == CNT_W'(SAMPLE_CYCLES - 1));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			smp_cnt <= '0;
			history <= '0;
		end
		else if (smp_en)
		begin
			smp_cnt <= '0;
			history <= {history[2:0], pb_in}; // shift in new sample
		end
		else
			smp_cnt <= smp_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pb_debounced <= 1'b0;
		else if (history == 4'hF)
			pb_debounced <= 1'b1; // four highs in a row
		else if (history == 4'h0)
			pb_debounced <= 1'b0; // four lows in a row
	end
endmodule

`default_nettype wire

//--- src/count_down.sv
`timescale 1ns/1ps
`default_nettype none

module count_down #(
	parameter int START_COUNT = 10,  // seconds, up to 99
	parameter int TICK_CYCLES = 100  // clocks per second
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  screen_pkg::fsm_state_t   state,
	output screen_pkg::glyph_t [3:0] glyphs, // lead, tens, units, trail
	output logic                     done    // count hit zero
);
	localparam int TICK_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

	logic [TICK_W-1:0] tick_cnt; // prescaler
	logic              tick;     // one second elapsed
	logic              active;   // screen selected
	logic [6:0]        count;    // seconds left
	logic [6:0]        tens;
	logic [6:0]        units;

	assign active = (state == screen_pkg::ST_COUNT_DOWN);
	assign tick   = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

	//////////////////////////////////////////////////////////////////////
	// prescaler and seconds counter
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!rst_n || !active)
			tick_cnt <= '0; // restart the second on entry
		else if (tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n || !active)
			count <= 7'(START_COUNT); // reload outside the state
		else if (tick && count != '0)
			count <= count - 1'b1; // hold once at zero
	end

	// done drops together with the reload when the state is left
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			done <= 1'b0;
		else
			done <= active && (count == '0);
	end

	//////////////////////////////////////////////////////////////////////
	// digit split and glyph register
	//////////////////////////////////////////////////////////////////////
	assign tens  = count / 7'd10;
	assign units = count % 7'd10;

	always_ff @(posedge clk)
	begin
		glyphs[3] <= (count == '0) ? screen_pkg::GLYPH_GO : screen_pkg::GLYPH_COLON;
		glyphs[2] <= screen_pkg::GLYPH_DIGIT_0 + 8'(tens);
		glyphs[1] <= screen_pkg::GLYPH_DIGIT_0 + 8'(units);
		glyphs[0] <= screen_pkg::GLYPH_BLANK; // trail cell stays empty
	end

	a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
		count <= 7'(START_COUNT))
		else $error("count above start value");

	a_done_zero: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (count == '0))
		else $error("done raised with seconds left");
endmodule

`default_nettype wire

//--- src/emotion_codec.sv
`timescale 1ns/1ps
`default_nettype none

module emotion_codec (
	emotion_if.codec emo // key and codes in, glyphs out
);
	// own key to outgoing code and face
	always_comb
	begin
		emo.code_out    = screen_pkg::EMO_NONE; // default, no pick
		emo.glyph_local = screen_pkg::GLYPH_BLANK;
		if (emo.key_valid)
		begin
			case (emo.key)
				screen_pkg::KEY_A:
				begin
					emo.code_out    = screen_pkg::EMO_SMILE;
					emo.glyph_local = screen_pkg::GLYPH_SMILE;
				end
				screen_pkg::KEY_2:
				begin
					emo.code_out    = screen_pkg::EMO_ANGRY;
					emo.glyph_local = screen_pkg::GLYPH_ANGRY;
				end
				screen_pkg::KEY_5:
				begin
					emo.code_out    = screen_pkg::EMO_SLEEPY;
					emo.glyph_local = screen_pkg::GLYPH_SLEEPY;
				end
				screen_pkg::KEY_8:
				begin
					emo.code_out    = screen_pkg::EMO_SHINE;
					emo.glyph_local = screen_pkg::GLYPH_SHINE;
				end
				screen_pkg::KEY_0:
				begin
					emo.code_out    = screen_pkg::EMO_LOVE;
					emo.glyph_local = screen_pkg::GLYPH_LOVE;
				end
				screen_pkg::KEY_1:
				begin
					emo.code_out    = screen_pkg::EMO_SAD;
					emo.glyph_local = screen_pkg::GLYPH_SAD;
				end
				screen_pkg::KEY_4:
				begin
					emo.code_out    = screen_pkg::EMO_LIKE;
					emo.glyph_local = screen_pkg::GLYPH_LIKE;
				end
				screen_pkg::KEY_7:
				begin
					emo.code_out    = screen_pkg::EMO_SCORN;
					emo.glyph_local = screen_pkg::GLYPH_SCORN;
				end
				default:
				begin
					emo.code_out    = screen_pkg::EMO_NONE; // unmapped key
					emo.glyph_local = screen_pkg::GLYPH_BLANK;
				end
			endcase
		end
	end

	// partner code to face
	always_comb
	begin
		case (emo.code_in)
			screen_pkg::EMO_SMILE:  emo.glyph_remote = screen_pkg::GLYPH_SMILE;
			screen_pkg::EMO_ANGRY:  emo.glyph_remote = screen_pkg::GLYPH_ANGRY;
			screen_pkg::EMO_SLEEPY: emo.glyph_remote = screen_pkg::GLYPH_SLEEPY;
			screen_pkg::EMO_SHINE:  emo.glyph_remote = screen_pkg::GLYPH_SHINE;
			screen_pkg::EMO_LOVE:   emo.glyph_remote = screen_pkg::GLYPH_LOVE;
			screen_pkg::EMO_SAD:    emo.glyph_remote = screen_pkg::GLYPH_SAD;
			screen_pkg::EMO_LIKE:   emo.glyph_remote = screen_pkg::GLYPH_LIKE;
			screen_pkg::EMO_SCORN:  emo.glyph_remote = screen_pkg::GLYPH_SCORN;
			default:                emo.glyph_remote = screen_pkg::GLYPH_BLANK; // none or junk
		endcase
	end

	// the other board only understands 0 to 8
	a_code_range: assert property (@(posedge emo.clk)
		emo.code_out <= screen_pkg::EMO_NONE)
		else $error("outgoing emotion code out of range");
endmodule

`default_nettype wire

//--- src/count_down_screen.sv
`timescale 1ns/1ps
`default_nettype none

module count_down_screen #(
	parameter int START_COUNT   = 10,  // seconds
	parameter int TICK_CYCLES   = 100, // clocks per second
	parameter int SAMPLE_CYCLES = 4    // clocks per debounce sample
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  screen_pkg::fsm_state_t  state,      // game FSM state
	input  screen_pkg::key_t        key,        // keypad code
	input  logic                    pressed,    // raw press level
	input  screen_pkg::emotion_t    code_in,    // partner emotion
	output logic                    next_state, // count finished
	output screen_pkg::emotion_t    code_out,   // own emotion
	output screen_pkg::screen_row_t row         // LCD text row
);
	screen_pkg::glyph_t [3:0] cd_glyphs; // lead, tens, units, trail
	logic                     cd_done;

	emotion_if emo (.clk(clk)); // key path between debouncer and codec

	//////////////////////////////////////////////////////////////////////
	// seconds counter
	//////////////////////////////////////////////////////////////////////
	count_down #(
		.START_COUNT(START_COUNT),
		.TICK_CYCLES(TICK_CYCLES)
	) count_down0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.state  (state),
		.glyphs (cd_glyphs),
		.done   (cd_done)
	);

	//////////////////////////////////////////////////////////////////////
	// key path
	//////////////////////////////////////////////////////////////////////
	debounce #(
		.SAMPLE_CYCLES(SAMPLE_CYCLES)
	) debounce0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.pb_in        (pressed),
		.pb_debounced (emo.key_valid) // qualifies the key
	);

	assign emo.key     = key;
	assign emo.code_in = code_in;

	emotion_codec emotion_codec0 (
		.emo(emo.codec)
	);

	assign code_out   = emo.code_out;
	assign next_state = cd_done; // FSM moves on at zero

	// left to right: 5 blanks, lead, tens, blank, own face, units,
	// trail, partner face, 4 blanks
	assign row = {{5{screen_pkg::GLYPH_BLANK}},
		cd_glyphs[3],
		cd_glyphs[2],
		screen_pkg::GLYPH_BLANK,
		emo.glyph_local,
		cd_glyphs[1],
		cd_glyphs[0],
		emo.glyph_remote,
		{4{screen_pkg::GLYPH_BLANK}}};
endmodule

`default_nettype wire

//--- src/screen_top.sv
`timescale 1ns/1ps
`default_nettype none

module screen_top #(
	parameter int START_COUNT   = 10,  // seconds shown first
	parameter int TICK_CYCLES   = 100, // clocks per second
	parameter int SAMPLE_CYCLES = 4    // clocks per key sample
) (
	input  logic                    clk,        // board clock
	input  logic                    rst_n,      // sync, active low
	input  screen_pkg::fsm_state_t  state,      // from game FSM
	input  screen_pkg::key_t        key,        // from keypad scanner
	input  logic                    pressed,    // from keypad scanner
	input  screen_pkg::emotion_t    code_in,    // from other board
	output logic                    next_state, // to game FSM
	output screen_pkg::emotion_t    code_out,   // to other board
	output screen_pkg::screen_row_t row         // to LCD driver
);
	count_down_screen #(
		.START_COUNT   (START_COUNT),
		.TICK_CYCLES   (TICK_CYCLES),
		.SAMPLE_CYCLES (SAMPLE_CYCLES)
	) count_down_screen0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.state      (state),
		.key        (key),
		.pressed    (pressed),
		.code_in    (code_in),
		.next_state (next_state),
		.code_out   (code_out),
		.row        (row)
	);
endmodule

`default_nettype wire

//--- verification/tb_screen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_screen;
	localparam int START_COUNT   = 3; // seconds
	localparam int TICK_CYCLES   = 8; // clocks per second
	localparam int SAMPLE_CYCLES = 2; // clocks per key sample

	logic                    clk;
	logic                    rst_n;
	screen_pkg::fsm_state_t  state;
	screen_pkg::key_t        key;
	logic                    pressed;
	screen_pkg::emotion_t    code_in;
	logic                    next_state;
	screen_pkg::emotion_t    code_out;
	screen_pkg::screen_row_t row;

	int errors;   // wrong values
	int failures; // timeouts and bad trace lines

	screen_top #(
		.START_COUNT   (START_COUNT),
		.TICK_CYCLES   (TICK_CYCLES),
		.SAMPLE_CYCLES (SAMPLE_CYCLES)
	) dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.state      (state),
		.key        (key),
		.pressed    (pressed),
		.code_in    (code_in),
		.next_state (next_state),
		.code_out   (code_out),
		.row        (row)
	);

	always #50 clk = ~clk; // 100 ns period

	//////////////////////////////////////////////////////////////////////
	// trace helpers called at a falling edge
	//////////////////////////////////////////////////////////////////////
	task automatic run_cycles(input int n);
		repeat (n) @(negedge clk); // bounded by n
	endtask

	task automatic wait_next_state(input int limit);
		int cycles;
		cycles = 0;
		while (!next_state && cycles < limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!next_state)
		begin
			$display("timeout: next_state still low after %0d cycles", limit);
			failures++;
		end
	endtask

	task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp)
		else
		begin
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		int          fd;
		int          n;
		string       line;
		byte         cmd;
		logic [31:0] a;
		logic [31:0] b;
		clk      = 1'b0;
		rst_n    = 1'b0; // held for two rising edges
		state    = screen_pkg::ST_IDLE;
		key      = screen_pkg::KEY_NONE;
		pressed  = 1'b0;
		code_in  = screen_pkg::EMO_NONE;
		errors   = 0;
		failures = 0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		fd = $fopen("verification/screen_trace.txt", "r");
		if (fd == 0)
		begin
			$display("could not open verification/screen_trace.txt");
			failures++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				n    = $fgets(line, fd);
				cmd  = "#"; // blank lines fall through as comments
				a    = '0;
				b    = '0;
				n    = $sscanf(line, "%c %h %h", cmd, a, b);
				case (cmd)
					"S": state = screen_pkg::fsm_state_t'(a);
					"K":
					begin
						key     = screen_pkg::key_t'(a);
						pressed = b[0];
					end
					"C": code_in = screen_pkg::emotion_t'(a);
					"R": run_cycles(int'(a));
					"W": wait_next_state(int'(a));
					"N": check_value("next_state", {7'd0, next_state}, a[7:0]);
					"O": check_value("code_out", {4'd0, code_out}, a[7:0]);
					"B": check_value($sformatf("row[%0d]", a[3:0]), row[a[3:0]], b[7:0]);
					"#": ; // comment line
					default:
					begin
						$display("unknown trace command in line: %s", line);
						failures++;
					end
				endcase
			end
			$fclose(fd);
		end
		$display("value errors: %0d, other failures: %0d", errors, failures);
		if (errors == 0 && failures == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end
endmodule

`default_nettype wire

//--- verification/screen_trace.txt
# cmd a b, hex: S state | K key pressed | C code_in | R cycles | W limit
# N next_state | O code_out | B row_index glyph (index f is leftmost)
R 1
N 0
O 8
B f 20
B b 20
B 8 20
B 5 20
B 0 20
# count-down, done one tick after the units reach zero
S 1
R 1
B a 3a
B 9 30
B 6 33
R 8
B 6 32
R 8
B 6 31
R 7
N 0
W 1
B a 47
B 6 30
S 0
R 2
N 0
B a 3a
B 6 33
# emotion keys, pressed stays high
K a 1
R a
O 0
B 7 00
K 2 1
R 1
O 1
B 7 01
K 5 1
R 1
O 2
B 7 02
K 8 1
R 1
O 3
B 7 03
K 0 1
R 1
O 4
B 7 04
K 1 1
R 1
O 5
B 7 05
K 4 1
R 1
O 6
B 7 06
K 7 1
R 1
O 7
B 7 07
K 3 1
R 1
O 8
B 7 20
K f 0
R a
O 8
# short press, one high sample
K a 1
R 2
O 8
K a 0
R a
O 8
# remote codes
C 0
R 1
B 4 00
C 1
R 1
B 4 01
C 2
R 1
B 4 02
C 3
R 1
B 4 03
C 4
R 1
B 4 04
C 5
R 1
B 4 05
C 6
R 1
B 4 06
C 7
R 1
B 4 07
C 8
R 1
B 4 20
C f
R 1
B 4 20

//--- list.f
src/screen_pkg.sv
src/emotion_if.sv
src/debounce.sv
src/count_down.sv
src/emotion_codec.sv
src/count_down_screen.sv
src/screen_top.sv
verification/tb_screen.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_screen
	./obj_dir/Vtb_screen | tee /dev/stderr | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
